/* dv/loader_testdata.txt */
# name  base_addr(hex)  target_core(dec)  stall_mask(hex, set bit = waitrequest high)
# one job per line, run in order
core0_no_stall     0000000000010000  0  00
core1_no_stall     0000000100002000  1  00
core1_stalled      0000000100002000  1  5a
core2_stalled      00000000fffff000  2  b6
core3_no_stall     7f00000000000c40  3  00
core3_heavy_stall  7f00000000000c40  3  ee
core0_unaligned    0000123456789a24  0  13
core2_wrap_base    ffffffffffffff00  2  31

/* files.f */
src/loader_pkg.sv
src/line_fetcher.sv
src/line_buffer.sv
src/word_writer.sv
src/core_memory_loader.sv
dv/loader_assertions.sv
dv/tb_core_memory_loader.sv

/* dv/tb_core_memory_loader.sv */
`timescale 1ns/100ps

module tb_core_memory_loader;

    import loader_pkg::*;

    logic                 clk;
    logic                 reset;
    logic                 kick;
    logic                 busy;
    logic [63:0]          memory_base_addr;
    logic [CORE_BITS-1:0] target_core;
    avm_req_t             m0_req;
    avm_rsp_t             m0_rsp;
    insn_write_t          insn_write;
    data_write_t          data_write;

    string       job_name[$];
    logic [63:0] job_base[$];
    int          job_core[$];
    logic [7:0]  job_mask[$];
    logic        jobs_loaded = 1'b0;

    string       cur_name = "reset";
    logic [63:0] cur_base;
    int          cur_core;
    logic [7:0]  cur_mask;
    logic        job_active = 1'b0;
    logic        last_seen;
    int          insn_count;
    int          data_count;
    int          read_idx;
    int          stall_pos;

    // memory model state
    logic [63:0] rng = 64'd60919;
    logic        pending = 1'b0;
    int          lat_count;
    logic [63:0] pend_addr;

    core_memory_loader i_dut (
        .clk              (clk),
        .reset            (reset),
        .kick             (kick),
        .busy             (busy),
        .memory_base_addr (memory_base_addr),
        .target_core      (target_core),
        .m0_req           (m0_req),
        .m0_rsp           (m0_rsp),
        .insn_write       (insn_write),
        .data_write       (data_write)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [63:0] xorshift(input logic [63:0] x);
        logic [63:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 7);
        s = s ^ (s << 17);
        return s;
    endfunction

    function automatic logic [31:0] line_word(input logic [63:0] line_addr, input int k);
        logic [63:0] s;
        s = xorshift(line_addr + 64'(k));
        return s[31:0];
    endfunction

    function automatic logic [LINE_BITS-1:0] make_line(input logic [63:0] line_addr);
        logic [LINE_BITS-1:0] line;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            line[LINE_BITS - 1 - 32 * k -: 32] = line_word(line_addr, k);  // word 0 on top
        end
        return line;
    endfunction

    task automatic fail_run(input string why);
        if (why.len() > 0) begin
            $display("ERROR: %s", why);
        end
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH test=%s %s expected=%0h actual=%0h",
                     cur_name, what, expected, actual);
            fail_run("");
        end
    endtask

    task automatic check_outputs();
        int          n;
        int          k;
        logic [63:0] line_addr;
        if (!job_active) begin
            check_value("busy while idle", 0, busy);
            check_value("insn we while idle", 0, insn_write.we);
            check_value("data we while idle", 0, data_write.we);
        end else if (last_seen) begin
            check_value("busy after last data word", 0, busy);
            check_value("insn we after last data word", 0, insn_write.we);
            check_value("data we after last data word", 0, data_write.we);
            job_active = 1'b0;
        end else begin
            check_value("busy during job", 1, busy);
            if (insn_write.we) begin
                if (insn_count >= INSN_LINES * WORDS_PER_LINE) begin
                    check_value("insn write count", INSN_LINES * WORDS_PER_LINE, insn_count + 1);
                end
                n = insn_count / WORDS_PER_LINE;
                k = insn_count % WORDS_PER_LINE;
                line_addr = cur_base + 64'(n) * 64;
                check_value("insn data", line_word(line_addr, k), insn_write.data);
                check_value("insn addr", (64'(cur_core) << (INSN_DEPTH + 2)) | 64'(insn_count * 4),
                            insn_write.addr);
                insn_count++;
            end
            if (data_write.we) begin
                check_value("insn writes before data", INSN_LINES * WORDS_PER_LINE, insn_count);
                n = INSN_LINES + data_count / WORDS_PER_LINE;
                k = data_count % WORDS_PER_LINE;
                line_addr = cur_base + 64'(n) * 64;
                check_value("data data", line_word(line_addr, k), data_write.data);
                check_value("data addr", (64'(cur_core) << (DMEM_DEPTH + 2)) | 64'(data_count * 4),
                            data_write.addr);
                data_count++;
                if (data_count == DATA_LINES * WORDS_PER_LINE) begin
                    last_seen = 1'b1;  // busy must drop on the next edge
                end
            end
        end
    endtask

    task automatic drive_memory();
        logic [63:0] expected_addr;
        m0_rsp.readdatavalid = 1'b0;
        m0_rsp.waitrequest = 1'b0;
        if (pending) begin
            lat_count--;
            if (lat_count == 0) begin
                m0_rsp.readdatavalid = 1'b1;
                m0_rsp.readdata = make_line(pend_addr);
                pending = 1'b0;
            end
        end
        if (m0_req.read) begin
            if (!job_active) begin
                fail_run("read request seen outside a job");
            end
            m0_rsp.waitrequest = cur_mask[stall_pos];
            stall_pos = (stall_pos + 1) % 8;
            if (!m0_rsp.waitrequest) begin
                if (pending) begin
                    fail_run("second read issued while one is outstanding");
                end
                if (read_idx >= TOTAL_LINES) begin
                    fail_run("more reads issued than lines in the job");
                end
                expected_addr = cur_base + 64'(read_idx) * 64;
                check_value("read address", expected_addr, m0_req.address);
                read_idx++;
                pend_addr = m0_req.address;
                rng = xorshift(rng);
                lat_count = 1 + int'(rng % 4);  // 1 to 4 cycles
                pending = 1'b1;
            end
        end
    endtask

    // outputs are sampled at the falling edge, before new inputs go out
    task automatic tick();
        @(negedge clk);
        if (i_dut.i_assertions.error_count != 0) begin
            fail_run("a protocol assertion failed");
        end
        check_outputs();
        drive_memory();
    endtask

    task automatic run_job(input int j);
        cur_name = job_name[j];
        cur_base = job_base[j];
        cur_core = job_core[j];
        cur_mask = job_mask[j];
        insn_count = 0;
        data_count = 0;
        read_idx = 0;
        stall_pos = 0;
        last_seen = 1'b0;
        tick();
        memory_base_addr = cur_base;
        target_core = CORE_BITS'(cur_core);
        kick = 1'b1;
        job_active = 1'b1;
        #1;
        check_value("busy with kick", 1, busy);
        tick();
        kick = 1'b0;
        memory_base_addr = ~cur_base;
        target_core = CORE_BITS'(cur_core + 1);
        repeat (30) tick();
        kick = 1'b1;  // second kick lands mid-job
        tick();
        kick = 1'b0;
        while (job_active) begin
            tick();
        end
        check_value("reads accepted", TOTAL_LINES, read_idx);
        check_value("response left pending", 0, pending);
    endtask

    initial begin
        int          fd;
        string       line;
        string       name;
        logic [63:0] base;
        int          core;
        logic [7:0]  mask;
        reset = 1'b1;
        kick = 1'b0;
        memory_base_addr = '0;
        target_core = '0;
        m0_rsp = '0;
        fd = $fopen("dv/loader_testdata.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open dv/loader_testdata.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%s %h %d %h", name, base, core, mask) == 4) begin
                    job_name.push_back(name);
                    job_base.push_back(base);
                    job_core.push_back(core);
                    job_mask.push_back(mask);
                end
            end
        end
        $fclose(fd);
        if (job_name.size() == 0) begin
            fail_run("no jobs found in the test data file");
        end
        jobs_loaded = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        tick();
        check_value("read after reset", 0, m0_req.read);
        for (int j = 0; j < job_name.size(); j++) begin
            run_job(j);
        end
        repeat (4) tick();
        $display("All tests passed!");
        $finish;
    end

    // budget of 200 cycles per line for every job
    initial begin
        wait (jobs_loaded);
        repeat (200 * TOTAL_LINES * job_name.size() + 100) @(posedge clk);
        fail_run("timeout, a job did not finish in time");
    end

endmodule

/* dv/loader_assertions.sv */
`timescale 1ns/100ps

module loader_assertions (
    input logic                    clk,
    input logic                    reset,
    input loader_pkg::avm_req_t    m0_req,
    input loader_pkg::avm_rsp_t    m0_rsp,
    input loader_pkg::insn_write_t insn_write,
    input loader_pkg::data_write_t data_write,
    input logic [1:0]              free_slots
);

    int error_count = 0;  // failed assertions so far

    // request held while the memory stalls
    property req_held;
        @(posedge clk) disable iff (reset)
        m0_req.read && m0_rsp.waitrequest |=> m0_req.read && $stable(m0_req.address);
    endproperty

    property one_port_only;
        @(posedge clk) disable iff (reset)
        !(insn_write.we && data_write.we);
    endproperty

    property room_for_line;
        @(posedge clk) disable iff (reset)
        m0_rsp.readdatavalid |-> free_slots != 2'd0;
    endproperty

    assert property (req_held) else begin
        error_count++;
        $error("read request changed under waitrequest");
    end
    assert property (one_port_only) else begin
        error_count++;
        $error("both write strobes high");
    end
    assert property (room_for_line) else begin
        error_count++;
        $error("line returned into a full buffer");
    end

endmodule

bind core_memory_loader loader_assertions i_assertions (
    .clk        (clk),
    .reset      (reset),
    .m0_req     (m0_req),
    .m0_rsp     (m0_rsp),
    .insn_write (insn_write),
    .data_write (data_write),
    .free_slots (free_slots)
);

/* src/core_memory_loader.sv */
`timescale 1ns/100ps
`default_nettype none

module core_memory_loader (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          kick,
    output logic                          busy,
    input  logic [63:0]                   memory_base_addr,
    input  logic [loader_pkg::CORE_BITS-1:0] target_core,

    output loader_pkg::avm_req_t          m0_req,
    input  loader_pkg::avm_rsp_t          m0_rsp,

    output loader_pkg::insn_write_t       insn_write,
    output loader_pkg::data_write_t       data_write
);

    import loader_pkg::*;

    logic                 start;
    logic [1:0]           free_slots;
    logic [LINE_BITS-1:0] head_line;
    logic                 not_empty;
    logic                 pop;

    line_fetcher i_fetcher (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .memory_base_addr (memory_base_addr),
        .free_slots       (free_slots),
        .waitrequest      (m0_rsp.waitrequest),
        .rsp_valid        (m0_rsp.readdatavalid),
        .req              (m0_req)
    );

    // returned lines land here without a handshake
    line_buffer i_buffer (
        .clk        (clk),
        .reset      (reset),
        .wr_valid   (m0_rsp.readdatavalid),
        .wr_line    (m0_rsp.readdata),
        .pop        (pop),
        .head_line  (head_line),
        .not_empty  (not_empty),
        .free_slots (free_slots)
    );

    word_writer i_writer (
        .clk         (clk),
        .reset       (reset),
        .kick        (kick),
        .target_core (target_core),
        .head_line   (head_line),
        .not_empty   (not_empty),
        .pop         (pop),
        .start       (start),
        .busy        (busy),
        .insn_write  (insn_write),
        .data_write  (data_write)
    );

endmodule

`default_nettype wire

/* src/word_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module word_writer (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          kick,
    input  logic [loader_pkg::CORE_BITS-1:0] target_core,

    input  logic [511:0]                  head_line,
    input  logic                          not_empty,
    output logic                          pop,

    output logic                          start,
    output logic                          busy,
    output loader_pkg::insn_write_t       insn_write,
    output loader_pkg::data_write_t       data_write
);

    import loader_pkg::*;

    logic                      busy_reg;
    logic [CORE_BITS-1:0]      core_reg;
    logic [LINE_CNT_BITS-1:0]  line_cnt;
    logic [WORD_BITS-1:0]      word_cnt;
    logic [LINE_CNT_BITS-1:0]  data_line;
    logic                      all_lines;
    logic                      emit;
    logic                      in_insn;
    logic                      insn_we;
    logic                      data_we;
    logic [31:0]               word_data;
    logic [INSN_ADDR_BITS-1:0] insn_addr;
    logic [DATA_ADDR_BITS-1:0] data_addr;

    assign start = kick && !busy_reg;  // kick while busy is dropped
    assign busy = busy_reg | kick;

    assign all_lines = (line_cnt == LINE_CNT_BITS'(TOTAL_LINES));
    assign emit = busy_reg && not_empty && !all_lines;
    assign in_insn = (line_cnt < LINE_CNT_BITS'(INSN_LINES));
    assign data_line = line_cnt - LINE_CNT_BITS'(INSN_LINES);

    // head line leaves the buffer as its last word is registered
    assign pop = emit && (word_cnt == WORD_BITS'(WORDS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_reg <= 1'b0;
            line_cnt <= '0;
            word_cnt <= '0;
            insn_we <= 1'b0;
            data_we <= 1'b0;
        end else begin
            insn_we <= 1'b0;
            data_we <= 1'b0;
            if (start) begin
                busy_reg <= 1'b1;
                line_cnt <= '0;
                word_cnt <= '0;
            end else if (busy_reg) begin
                if (all_lines) begin
                    busy_reg <= 1'b0;  // cycle after the last data strobe
                end else if (not_empty) begin
                    insn_we <= in_insn;
                    data_we <= !in_insn;
                    word_cnt <= word_cnt + 1'b1;
                    if (pop) begin
                        line_cnt <= line_cnt + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            core_reg <= target_core;
        end
        if (emit) begin
            word_data <= head_line[LINE_BITS - 1 - 32 * word_cnt -: 32];  // msw first
            insn_addr <= {core_reg, line_cnt[INSN_LINE_BITS-1:0], word_cnt, 2'b00};
            data_addr <= {core_reg, data_line[DATA_LINE_BITS-1:0], word_cnt, 2'b00};
        end
    end

    assign insn_write = '{we: insn_we, addr: insn_addr, data: word_data};
    assign data_write = '{we: data_we, addr: data_addr, data: word_data};

endmodule

`default_nettype wire

/* src/line_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module line_buffer (
    input  logic         clk,
    input  logic         reset,

    input  logic         wr_valid,
    input  logic [511:0] wr_line,

    input  logic         pop,
    output logic [511:0] head_line,
    output logic         not_empty,
    output logic [1:0]   free_slots
);

    import loader_pkg::*;

    localparam int PTR_BITS = $clog2(BUF_LINES);

    logic [LINE_BITS-1:0] lines [BUF_LINES];
    logic [PTR_BITS-1:0]  wr_ptr;
    logic [PTR_BITS-1:0]  rd_ptr;
    logic [1:0]           count;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(BUF_LINES - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head_line = lines[rd_ptr];
    assign not_empty = (count != 2'd0);
    assign free_slots = 2'(BUF_LINES) - count;

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            lines[wr_ptr] <= wr_line;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
        end
    end

    // write and pop together leave the count alone
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= 2'd0;
        end else begin
            case ({wr_valid, pop})
                2'b10: begin
                    count <= count + 2'd1;
                end
                2'b01: begin
                    count <= count - 2'd1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/line_fetcher.sv */
`timescale 1ns/100ps
`default_nettype none

module line_fetcher (
    input  logic                clk,
    input  logic                reset,

    input  logic                start,
    input  logic [63:0]         memory_base_addr,

    input  logic [1:0]          free_slots,
    input  logic                waitrequest,
    input  logic                rsp_valid,
    output loader_pkg::avm_req_t req
);

    import loader_pkg::*;

    logic [63:0]              base_reg;
    logic [LINE_CNT_BITS-1:0] line_idx;  // reads accepted so far
    logic                     active;
    logic                     outstanding;
    logic                     room;
    logic                     issue;
    logic                     accept;
    logic                     last_line;
    logic [63:0]              line_offset;

    // a line may be requested only when its slot is guaranteed
    assign room = (free_slots != 2'd0) && !outstanding;

    assign issue = active && !req.read && room;

    assign accept = req.read && !waitrequest;

    assign last_line = (line_idx == LINE_CNT_BITS'(TOTAL_LINES - 1));

    assign line_offset = 64'(line_idx) << LINE_SHIFT;

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            line_idx <= '0;
        end else begin
            if (start) begin
                active <= 1'b1;
                line_idx <= '0;
            end else if (accept) begin
                line_idx <= line_idx + 1'b1;
                if (last_line) begin
                    active <= 1'b0;  // job done here, writer may still drain
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            base_reg <= memory_base_addr;
        end
    end

    // one read in flight at most
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else begin
            if (accept) begin
                outstanding <= 1'b1;
            end else if (rsp_valid) begin
                outstanding <= 1'b0;
            end
        end
    end

    // request held until waitrequest drops
    always_ff @(posedge clk) begin
        if (reset) begin
            req.read <= 1'b0;
        end else begin
            if (accept) begin
                req.read <= 1'b0;
            end else if (issue) begin
                req.read <= 1'b1;
                req.address <= base_reg + line_offset;
            end
        end
    end

endmodule

`default_nettype wire

/* src/loader_pkg.sv */
package loader_pkg;

    localparam int CORES          = 4;
    localparam int CORE_BITS      = $clog2(CORES);
    localparam int INSN_DEPTH     = 6;  // log2 insn words per core
    localparam int DMEM_DEPTH     = 7;  // log2 data words per core
    localparam int WORDS_PER_LINE = 16;
    localparam int WORD_BITS      = $clog2(WORDS_PER_LINE);
    localparam int INSN_LINES     = (2 ** INSN_DEPTH) / WORDS_PER_LINE;
    localparam int DATA_LINES     = (2 ** DMEM_DEPTH) / WORDS_PER_LINE;
    localparam int TOTAL_LINES    = INSN_LINES + DATA_LINES;
    localparam int LINE_CNT_BITS  = $clog2(TOTAL_LINES + 1);
    localparam int INSN_LINE_BITS = INSN_DEPTH - WORD_BITS;
    localparam int DATA_LINE_BITS = DMEM_DEPTH - WORD_BITS;
    localparam int LINE_BITS      = 512;
    localparam int LINE_SHIFT     = $clog2(LINE_BITS / 8);  // 64-byte lines
    localparam int BUF_LINES      = 2;
    localparam int INSN_ADDR_BITS = CORE_BITS + INSN_DEPTH + 2;
    localparam int DATA_ADDR_BITS = CORE_BITS + DMEM_DEPTH + 2;

    // single-beat read request toward system memory
    typedef struct packed {
        logic        read;
        logic [63:0] address;
    } avm_req_t;

    typedef struct packed {
        logic                 waitrequest;
        logic                 readdatavalid;
        logic [LINE_BITS-1:0] readdata;
    } avm_rsp_t;

    typedef struct packed {
        logic                      we;
        logic [INSN_ADDR_BITS-1:0] addr;  // byte address, core on top
        logic [31:0]               data;
    } insn_write_t;

    typedef struct packed {
        logic                      we;
        logic [DATA_ADDR_BITS-1:0] addr;
        logic [31:0]               data;
    } data_write_t;

endpackage
